//--- rtl/rv_sim_pkg.sv
package rv_sim_pkg;

  localparam logic [63:0] pc_start = 64'h8000_0000;

  localparam logic [6:0] op_addi   = 7'h13;
  localparam logic [6:0] op_op     = 7'h33;
  localparam logic [6:0] op_load   = 7'h03;
  localparam logic [6:0] op_store  = 7'h23;
  localparam logic [6:0] op_branch = 7'h63;
  localparam logic [6:0] op_trap   = 7'h6b; // Simulator halt, code in a0.

  localparam logic [2:0] funct3_beq = 3'b000;
  localparam logic [2:0] funct3_bne = 3'b001;
  localparam logic [2:0] funct3_ld  = 3'b011;
  localparam logic [2:0] funct3_sd  = 3'b011;
  localparam logic [6:0] funct7_sub = 7'b0100000;

  typedef struct packed {
    logic        cen;
    logic        wen;
    logic [63:0] addr;
    logic [63:0] wdata;
    logic [7:0]  wmask;
  } mem_req_t;

  // Every view covers the same 32 bits of the fetched word.
  typedef union packed {
    struct packed {
      logic [6:0] funct7;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [4:0] rd;
      logic [6:0] opcode;
    } r_view;
    struct packed {
      logic [11:0] imm12;
      logic [4:0]  rs1;
      logic [2:0]  funct3;
      logic [4:0]  rd;
      logic [6:0]  opcode;
    } i_view;
    struct packed {
      logic [6:0] imm_hi;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [4:0] imm_lo;
      logic [6:0] opcode;
    } s_view;
    struct packed {
      logic       imm12;
      logic [5:0] imm10_5;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [3:0] imm4_1;
      logic       imm11;
      logic [6:0] opcode;
    } b_view;
  } inst_t;

  typedef struct packed {
    logic        valid;
    logic [63:0] pc;
    logic [31:0] inst;
    logic        wen;
    logic [4:0]  wdest;
    logic [63:0] wdata;
  } commit_t;

  typedef struct packed {
    logic        valid;
    logic [7:0]  code;
    logic [63:0] pc;
    logic [63:0] cycle_cnt;
    logic [63:0] instr_cnt;
  } trap_t;

  typedef enum logic [2:0] {
    idle,
    fetch_req,
    fetch_wait,
    execute,
    mem_req,
    mem_wait,
    writeback,
    halted
  } core_state_t;

endpackage

//--- rtl/core_control_fsm.sv
`timescale 1ns/1ps

module core_control_fsm import rv_sim_pkg::*; (
  input  logic        clock,
  input  logic        reset,
  input  logic        run_i,
  input  logic        mem_ready_i,
  input  logic        is_mem_i,
  input  logic        is_trap_i,
  output core_state_t state_o,
  output logic        fetch_en_o,
  output logic        latch_inst_o,
  output logic        exec_en_o,
  output logic        mem_en_o,
  output logic        wb_en_o,
  output logic        trap_hit_o
);

  core_state_t state_q;
  core_state_t state_d;

  always_comb begin
    state_d = state_q;
    case (state_q)
      idle:       if (run_i) state_d = fetch_req;
      fetch_req:  state_d = fetch_wait;
      fetch_wait: if (mem_ready_i) state_d = execute;
      execute: begin
        if (is_trap_i) begin
          state_d = halted;
        end else if (is_mem_i) begin
          state_d = mem_req;
        end else begin
          state_d = writeback;
        end
      end
      mem_req:    state_d = mem_wait;
      mem_wait:   if (mem_ready_i) state_d = writeback;
      writeback:  state_d = fetch_req;
      halted:     state_d = halted; // Only reset leaves this state.
      default:    state_d = idle;
    endcase
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      state_q <= idle;
    end else begin
      state_q <= state_d;
    end
  end

  // Each strobe is one cycle wide since every state below lasts one cycle.
  assign fetch_en_o   = (state_q == fetch_req);
  assign latch_inst_o = (state_q == fetch_wait) && mem_ready_i;
  assign exec_en_o    = (state_q == execute);
  assign mem_en_o     = (state_q == mem_req);
  assign wb_en_o      = (state_q == writeback);
  assign trap_hit_o   = (state_q == execute) && is_trap_i;
  assign state_o      = state_q;

endmodule

//--- rtl/commit_counter.sv
`timescale 1ns/1ps

module commit_counter (
  input  logic        clock,
  input  logic        reset,
  input  logic        busy_i,
  input  logic        retire_i,
  input  logic        trap_hit_i,
  output logic [63:0] cycle_cnt_o,
  output logic [63:0] instr_cnt_o
);

  logic trapped_q;

  // The trap cycle itself still counts, the counters hold from the next one.
  always_ff @(posedge clock) begin
    if (reset) begin
      trapped_q   <= 1'b0;
      cycle_cnt_o <= '0;
      instr_cnt_o <= '0;
    end else if (!trapped_q) begin
      trapped_q <= trap_hit_i;
      if (busy_i) begin
        cycle_cnt_o <= cycle_cnt_o + 64'd1;
      end
      if (retire_i) begin
        instr_cnt_o <= instr_cnt_o + 64'd1;
      end
    end
  end

endmodule

//--- rtl/reg_file.sv
`timescale 1ns/1ps

module reg_file (
  input  logic        clock,
  input  logic        reset,
  input  logic [4:0]  rs1_addr_i,
  input  logic [4:0]  rs2_addr_i,
  output logic [63:0] rs1_data_o,
  output logic [63:0] rs2_data_o,
  input  logic        rd_wen_i,
  input  logic [4:0]  rd_addr_i,
  input  logic [63:0] rd_wdata_i,
  input  logic [4:0]  obs_addr_i,
  output logic [63:0] obs_data_o
);

  logic [63:0] regs [32];

  always_ff @(posedge clock) begin
    if (reset) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (rd_wen_i && (rd_addr_i != 5'd0)) begin
      regs[rd_addr_i] <= rd_wdata_i; // x0 is never written, so it reads zero.
    end
  end

  assign rs1_data_o = regs[rs1_addr_i];
  assign rs2_data_o = regs[rs2_addr_i];
  assign obs_data_o = regs[obs_addr_i];

endmodule

//--- rtl/exec_unit.sv
`timescale 1ns/1ps

module exec_unit import rv_sim_pkg::*; (
  input  logic        clock,
  input  logic        reset,
  input  logic        fetch_en_i,
  input  logic        latch_inst_i,
  input  logic        exec_en_i,
  input  logic        mem_en_i,
  input  logic        wb_en_i,
  input  logic [63:0] mem_rdata_i,
  input  logic [63:0] rs1_data_i,
  input  logic [63:0] rs2_data_i,
  output logic [4:0]  rs1_addr_o,
  output logic [4:0]  rs2_addr_o,
  output logic        rd_wen_o,
  output logic [4:0]  rd_addr_o,
  output logic [63:0] rd_wdata_o,
  output mem_req_t    mem_req_o,
  output logic        is_mem_o,
  output logic        is_trap_o,
  output logic [63:0] pc_o,
  output inst_t       inst_o
);

  logic [63:0] pc_q;
  logic [63:0] inst_pc_q;
  inst_t       inst_q;
  logic [6:0]  opcode;
  logic [2:0]  funct3;
  logic        is_addi;
  logic        is_op;
  logic        is_load;
  logic        is_store;
  logic        is_branch;
  logic        is_trap;
  logic [63:0] imm_i;
  logic [63:0] imm_s;
  logic [63:0] imm_b;
  logic [63:0] alu_result;
  logic [63:0] mem_addr;
  logic        taken;

  assign opcode    = inst_q.r_view.opcode;
  assign funct3    = inst_q.r_view.funct3;
  assign is_addi   = (opcode == op_addi);
  assign is_op     = (opcode == op_op);
  assign is_load   = (opcode == op_load) && (funct3 == funct3_ld);
  assign is_store  = (opcode == op_store) && (funct3 == funct3_sd);
  assign is_branch = (opcode == op_branch);
  assign is_trap   = (opcode == op_trap);

  assign imm_i = {{52{inst_q.i_view.imm12[11]}}, inst_q.i_view.imm12};
  assign imm_s = {{52{inst_q.s_view.imm_hi[6]}}, inst_q.s_view.imm_hi, inst_q.s_view.imm_lo};
  assign imm_b = {{51{inst_q.b_view.imm12}}, inst_q.b_view.imm12, inst_q.b_view.imm11,
                  inst_q.b_view.imm10_5, inst_q.b_view.imm4_1, 1'b0};

  always_comb begin
    if (is_op && (inst_q.r_view.funct7 == funct7_sub)) begin
      alu_result = rs1_data_i - rs2_data_i;
    end else if (is_op) begin
      alu_result = rs1_data_i + rs2_data_i;
    end else begin
      alu_result = rs1_data_i + imm_i;
    end
  end

  assign mem_addr = rs1_data_i + (is_store ? imm_s : imm_i);
  assign taken = ((funct3 == funct3_beq) && (rs1_data_i == rs2_data_i)) ||
                 ((funct3 == funct3_bne) && (rs1_data_i != rs2_data_i));

  always_ff @(posedge clock) begin
    if (reset) begin
      pc_q      <= pc_start;
      inst_pc_q <= pc_start;
      inst_q    <= '0;
    end else begin
      if (latch_inst_i) begin
        inst_q    <= pc_q[2] ? mem_rdata_i[63:32] : mem_rdata_i[31:0]; // Pick the word half.
        inst_pc_q <= pc_q;
      end
      if (exec_en_i && is_branch) begin
        pc_q <= taken ? inst_pc_q + imm_b : pc_q + 64'd4;
      end else if (wb_en_i && !is_branch) begin
        pc_q <= pc_q + 64'd4;
      end
    end
  end

  always_comb begin
    mem_req_o = '0;
    if (fetch_en_i) begin
      mem_req_o.cen  = 1'b1;
      mem_req_o.addr = pc_q;
    end else if (mem_en_i) begin
      mem_req_o.cen   = 1'b1;
      mem_req_o.wen   = is_store;
      mem_req_o.addr  = mem_addr;
      mem_req_o.wdata = rs2_data_i;
      mem_req_o.wmask = 8'hff; // Only doubleword accesses exist.
    end
  end

  // The trap reads its code from a0.
  assign rs1_addr_o = is_trap ? 5'd10 : inst_q.r_view.rs1;
  assign rs2_addr_o = inst_q.r_view.rs2;
  assign rd_addr_o  = inst_q.r_view.rd;
  assign rd_wen_o   = wb_en_i && (is_addi || is_op || is_load) && (rd_addr_o != 5'd0);
  assign rd_wdata_o = is_load ? mem_rdata_i : alu_result;

  assign is_mem_o  = is_load || is_store;
  assign is_trap_o = is_trap;
  assign pc_o      = inst_pc_q;
  assign inst_o    = inst_q;

endmodule

//--- rtl/sim_ram.sv
`timescale 1ns/1ps

module sim_ram import rv_sim_pkg::*; #(
  parameter int ram_words = 1024
) (
  input  logic        clock,
  input  logic        reset,
  input  mem_req_t    req_i,
  output logic        ready_o,
  output logic [63:0] rdata_o
);

  localparam int addr_bits = $clog2(ram_words);

  logic [63:0]          mem [ram_words];
  logic [63:0]          offset;
  logic [addr_bits-1:0] idx;
  logic [63:0]          bit_mask;

  // Byte 0 of the RAM sits at the start address of the program.
  assign offset = req_i.addr - pc_start;
  assign idx    = offset[addr_bits+2:3];

  always_comb begin
    for (int b = 0; b < 8; b++) begin
      bit_mask[8*b +: 8] = {8{req_i.wmask[b]}};
    end
  end

  always_ff @(posedge clock) begin
    if (req_i.cen && req_i.wen) begin
      mem[idx] <= (mem[idx] & ~bit_mask) | (req_i.wdata & bit_mask);
    end
    if (req_i.cen && !req_i.wen) begin
      rdata_o <= mem[idx]; // Held until the next read.
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      ready_o <= 1'b0;
    end else begin
      ready_o <= req_i.cen;
    end
  end

endmodule

//--- rtl/rv_sim_top.sv
`timescale 1ns/1ps

module rv_sim_top import rv_sim_pkg::*; #(
  parameter int ram_words = 1024
) (
  input  logic        clock,
  input  logic        reset,
  input  logic        run_i,
  input  logic        load_valid_i,
  input  logic [63:0] load_addr_i,
  input  logic [63:0] load_data_i,
  input  logic [4:0]  obs_addr_i,
  output logic [63:0] obs_data_o,
  output commit_t     commit_o,
  output trap_t       trap_o,
  output logic        halted_o
);

  core_state_t state;
  logic        fetch_en;
  logic        latch_inst;
  logic        exec_en;
  logic        mem_en;
  logic        wb_en;
  logic        trap_hit;
  logic        is_mem;
  logic        is_trap;
  logic        mem_ready;
  logic [63:0] mem_rdata;
  mem_req_t    core_req;
  mem_req_t    ram_req;
  logic [4:0]  rs1_addr;
  logic [4:0]  rs2_addr;
  logic [63:0] rs1_data;
  logic [63:0] rs2_data;
  logic        rd_wen;
  logic [4:0]  rd_addr;
  logic [63:0] rd_wdata;
  logic [63:0] pc;
  inst_t       inst;
  logic [63:0] cycle_cnt;
  logic [63:0] instr_cnt;
  logic        trap_valid_q;
  logic [7:0]  trap_code_q;
  logic [63:0] trap_pc_q;

  core_control_fsm i_core_control_fsm (
    .clock,
    .reset,
    .run_i,
    .mem_ready_i  (mem_ready),
    .is_mem_i     (is_mem),
    .is_trap_i    (is_trap),
    .state_o      (state),
    .fetch_en_o   (fetch_en),
    .latch_inst_o (latch_inst),
    .exec_en_o    (exec_en),
    .mem_en_o     (mem_en),
    .wb_en_o      (wb_en),
    .trap_hit_o   (trap_hit)
  );

  exec_unit i_exec_unit (
    .clock,
    .reset,
    .fetch_en_i   (fetch_en),
    .latch_inst_i (latch_inst),
    .exec_en_i    (exec_en),
    .mem_en_i     (mem_en),
    .wb_en_i      (wb_en),
    .mem_rdata_i  (mem_rdata),
    .rs1_data_i   (rs1_data),
    .rs2_data_i   (rs2_data),
    .rs1_addr_o   (rs1_addr),
    .rs2_addr_o   (rs2_addr),
    .rd_wen_o     (rd_wen),
    .rd_addr_o    (rd_addr),
    .rd_wdata_o   (rd_wdata),
    .mem_req_o    (core_req),
    .is_mem_o     (is_mem),
    .is_trap_o    (is_trap),
    .pc_o         (pc),
    .inst_o       (inst)
  );

  reg_file i_reg_file (
    .clock,
    .reset,
    .rs1_addr_i (rs1_addr),
    .rs2_addr_i (rs2_addr),
    .rs1_data_o (rs1_data),
    .rs2_data_o (rs2_data),
    .rd_wen_i   (rd_wen),
    .rd_addr_i  (rd_addr),
    .rd_wdata_i (rd_wdata),
    .obs_addr_i,
    .obs_data_o
  );

  commit_counter i_commit_counter (
    .clock,
    .reset,
    .busy_i      ((state != idle) && (state != halted)),
    .retire_i    (wb_en || trap_hit),
    .trap_hit_i  (trap_hit),
    .cycle_cnt_o (cycle_cnt),
    .instr_cnt_o (instr_cnt)
  );

  // The loader owns the RAM while the core sits idle.
  always_comb begin
    if (state == idle) begin
      ram_req = '{cen: load_valid_i, wen: 1'b1, addr: load_addr_i,
                  wdata: load_data_i, wmask: 8'hff};
    end else begin
      ram_req = core_req;
    end
  end

  sim_ram #(
    .ram_words (ram_words)
  ) i_sim_ram (
    .clock,
    .reset,
    .req_i   (ram_req),
    .ready_o (mem_ready),
    .rdata_o (mem_rdata)
  );

  always_ff @(posedge clock) begin
    if (reset) begin
      commit_o.valid <= 1'b0;
      trap_valid_q   <= 1'b0;
    end else begin
      commit_o.valid <= wb_en;
      if (trap_hit) begin
        trap_valid_q <= 1'b1;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (wb_en) begin
      commit_o.pc    <= pc;
      commit_o.inst  <= inst;
      commit_o.wen   <= rd_wen;
      commit_o.wdest <= rd_addr;
      commit_o.wdata <= rd_wdata;
    end
    if (trap_hit) begin
      trap_code_q <= rs1_data[7:0];
      trap_pc_q   <= pc;
    end
  end

  // The counters stop on the trap, so they read final once valid is up.
  assign trap_o = '{valid: trap_valid_q, code: trap_code_q, pc: trap_pc_q,
                    cycle_cnt: cycle_cnt, instr_cnt: instr_cnt};
  assign halted_o = (state == halted);

endmodule

//--- tests/tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen #(
  parameter int reset_cycles = 10
) (
  input  logic reset_req_i,
  output logic clock_o,
  output logic reset_o
);

  logic req_seen;
  int   count;

  initial begin
    clock_o  = 1'b0;
    reset_o  = 1'b1;
    req_seen = 1'b0;
    count    = reset_cycles;
  end

  always #20 clock_o = ~clock_o; // 40 ns period.

  always @(posedge clock_o) begin
    req_seen <= reset_req_i;
  end

  // Reset moves on the falling edge like every other DUT input.
  always @(negedge clock_o) begin
    if (req_seen) begin
      count = reset_cycles;
    end else if (count != 0) begin
      count = count - 1;
    end
    reset_o <= (count != 0);
  end

endmodule

//--- tests/rv_sim_tb.sv
`timescale 1ns/1ps

module rv_sim_tb import rv_sim_pkg::*; ();

  localparam int instr_budget = 48;
  localparam int num_tests    = 5;
  localparam int watchdog_ns  = (instr_budget * 6 + num_tests * 60) * 40;

  logic        clock;
  logic        reset;
  logic        reset_req;
  logic        run;
  logic        load_valid;
  logic [63:0] load_addr;
  logic [63:0] load_data;
  logic [4:0]  obs_addr;
  logic [63:0] obs_data;
  commit_t     commit;
  trap_t       trap;
  logic        halted;

  logic [31:0] prog [$];
  commit_t     exp_q [$];
  commit_t     got_q [$];
  int          exp_cycles;
  int          errors;
  int          tests_run;
  int          tests_failed;
  logic [31:0] rng = 32'h453336a7;

  tb_clock_gen i_tb_clock_gen (
    .reset_req_i (reset_req),
    .clock_o     (clock),
    .reset_o     (reset)
  );

  rv_sim_top #(
    .ram_words (1024)
  ) i_rv_sim_top (
    .clock,
    .reset,
    .run_i        (run),
    .load_valid_i (load_valid),
    .load_addr_i  (load_addr),
    .load_data_i  (load_data),
    .obs_addr_i   (obs_addr),
    .obs_data_o   (obs_data),
    .commit_o     (commit),
    .trap_o       (trap),
    .halted_o     (halted)
  );

  // Commit pulses last a full cycle, so the falling edge sees each one once.
  always @(negedge clock) begin
    if (!reset && commit.valid) begin
      got_q.push_back(commit);
    end
  end

  initial begin
    #(watchdog_ns);
    $display("Watchdog expired after %0d ns, the run did not finish.", watchdog_ns);
    $display("TEST FAIL");
    $finish;
  end

  function automatic logic [31:0] xorshift(logic [31:0] x);
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic logic [63:0] sext12(logic [11:0] v);
    return {{52{v[11]}}, v};
  endfunction

  function automatic logic [31:0] asm_i(logic [6:0] op, logic [4:0] rd, logic [2:0] f3,
                                        logic [4:0] rs1, logic [11:0] imm);
    return {imm, rs1, f3, rd, op};
  endfunction

  function automatic logic [31:0] asm_r(logic [6:0] f7, logic [4:0] rd, logic [4:0] rs1,
                                        logic [4:0] rs2);
    return {f7, rs2, rs1, 3'b000, rd, op_op};
  endfunction

  function automatic logic [31:0] asm_s(logic [4:0] rs2, logic [4:0] rs1, logic [11:0] imm);
    return {imm[11:5], rs2, rs1, funct3_sd, imm[4:0], op_store};
  endfunction

  function automatic logic [31:0] asm_b(logic [2:0] f3, logic [4:0] rs1, logic [4:0] rs2,
                                        logic [12:0] off);
    return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], op_branch};
  endfunction

  task automatic check_word(string name, logic [63:0] got, logic [63:0] exp);
    if (got !== exp) begin
      $display("[ERROR] %0t ns %s: got %h, expected %h", $time, name, got, exp);
      errors++;
    end
  endtask

  task automatic check_commit(commit_t got, commit_t exp);
    check_word("commit_o.pc", got.pc, exp.pc);
    check_word("commit_o.inst", 64'(got.inst), 64'(exp.inst));
    check_word("commit_o.wen", 64'(got.wen), 64'(exp.wen));
    if (exp.wen) begin
      check_word("commit_o.wdest", 64'(got.wdest), 64'(exp.wdest));
      check_word("commit_o.wdata", got.wdata, exp.wdata);
    end
  endtask

  task automatic check_trap(trap_t got, trap_t exp);
    check_word("trap_o.valid", 64'(got.valid), 64'(exp.valid));
    check_word("trap_o.code", 64'(got.code), 64'(exp.code));
    check_word("trap_o.pc", got.pc, exp.pc);
    check_word("trap_o.cycle_cnt", got.cycle_cnt, exp.cycle_cnt);
    check_word("trap_o.instr_cnt", got.instr_cnt, exp.instr_cnt);
  endtask

  task automatic new_program();
    prog.delete();
    exp_q.delete();
    got_q.delete();
    exp_cycles = 0;
  endtask

  // Expected commit of the instruction at word index idx of the program.
  task automatic expect_at(int idx, logic wen, logic [4:0] rd, logic [63:0] val);
    commit_t c;
    c       = '0;
    c.valid = 1'b1;
    c.pc    = pc_start + 64'(4 * idx);
    c.inst  = prog[idx];
    c.wen   = wen;
    c.wdest = rd;
    c.wdata = val;
    exp_q.push_back(c);
    if (prog[idx][6:0] == op_load || prog[idx][6:0] == op_store) begin
      exp_cycles += 6;
    end else begin
      exp_cycles += 4;
    end
  endtask

  task automatic put_exp(logic [31:0] ins, logic wen, logic [4:0] rd, logic [63:0] val);
    prog.push_back(ins);
    expect_at(prog.size() - 1, wen, rd, val);
  endtask

  task automatic reset_dut();
    @(negedge clock);
    reset_req = 1'b1;
    @(negedge clock);
    reset_req = 1'b0;
    @(negedge reset);
    @(negedge clock);
  endtask

  // Appends the trap, loads the program, runs it and checks commits and trap.
  task automatic run_program(logic [7:0] code);
    trap_t exp_trap;
    int    trap_idx;
    int    limit;
    int    waited;
    int    n_commits;
    trap_idx = prog.size();
    prog.push_back({25'd0, op_trap});
    if (prog.size() % 2 != 0) begin
      prog.push_back(32'h0);
    end
    reset_dut();
    for (int i = 0; i < prog.size(); i += 2) begin
      load_valid = 1'b1;
      load_addr  = pc_start + 64'(4 * i);
      load_data  = {prog[i+1], prog[i]};
      @(negedge clock);
    end
    load_valid = 1'b0;
    got_q.delete();
    run = 1'b1;
    @(negedge clock);
    run = 1'b0;
    limit  = 6 * prog.size() + 20;
    waited = 0;
    while (!halted && waited < limit) begin
      @(negedge clock);
      waited++;
    end
    if (!halted) begin
      $display("%0t ns: the core did not halt within %0d cycles.", $time, limit);
      errors++;
      return;
    end
    if (got_q.size() != exp_q.size()) begin
      $display("%0t ns: %0d commits seen, %0d expected.", $time, got_q.size(), exp_q.size());
      errors++;
    end
    for (int i = 0; i < got_q.size() && i < exp_q.size(); i++) begin
      check_commit(got_q[i], exp_q[i]);
    end
    exp_trap.valid     = 1'b1;
    exp_trap.code      = code;
    exp_trap.pc        = pc_start + 64'(4 * trap_idx);
    exp_trap.cycle_cnt = 64'(exp_cycles + 3);
    exp_trap.instr_cnt = 64'(exp_q.size() + 1);
    check_trap(trap, exp_trap);
    n_commits = got_q.size();
    repeat (5) @(negedge clock);
    if (!halted || !trap.valid || got_q.size() != n_commits) begin
      $display("%0t ns: the core did not stay halted after the trap.", $time);
      errors++;
    end
  endtask

  task automatic observe(logic [4:0] addr, logic [63:0] exp);
    obs_addr = addr;
    @(negedge clock);
    check_word($sformatf("obs_data_o[x%0d]", addr), obs_data, exp);
  endtask

  task automatic close_test(string name, int start);
    tests_run++;
    if (errors != start) begin
      tests_failed++;
      $display("%s: failed with %0d errors", name, errors - start);
    end else begin
      $display("%s: ok", name);
    end
  endtask

  task automatic test_alu_chain();
    logic [63:0] m [32];
    logic [11:0] imm;
    int          prev;
    int          a;
    int          start;
    start = errors;
    new_program();
    for (int r = 0; r < 32; r++) begin
      m[r] = '0;
    end
    prev = 0;
    for (int k = 0; k < 4; k++) begin
      a    = 1 + 3 * k;
      rng  = xorshift(rng);
      imm  = rng[11:0];
      m[a] = m[prev] + sext12(imm);
      put_exp(asm_i(op_addi, 5'(a), 3'b000, 5'(prev), imm), 1'b1, 5'(a), m[a]);
      m[a+1] = m[a] + m[prev];
      put_exp(asm_r(7'd0, 5'(a + 1), 5'(a), 5'(prev)), 1'b1, 5'(a + 1), m[a+1]);
      m[a+2] = m[prev] - m[a+1];
      put_exp(asm_r(funct7_sub, 5'(a + 2), 5'(prev), 5'(a + 1)), 1'b1, 5'(a + 2), m[a+2]);
      prev = a + 2;
    end
    run_program(m[10][7:0]); // x10 is written in the last round.
    close_test("alu chain", start);
  endtask

  task automatic test_load_store();
    logic [63:0] val;
    int          start;
    start = errors;
    new_program();
    val = sext12(12'h9a5);
    // The RAM decodes only the low address bits, so 0x400 lands past the program.
    put_exp(asm_i(op_addi, 5'd1, 3'b000, 5'd0, 12'h400), 1'b1, 5'd1, 64'h400);
    put_exp(asm_i(op_addi, 5'd2, 3'b000, 5'd0, 12'h9a5), 1'b1, 5'd2, val);
    put_exp(asm_s(5'd2, 5'd1, 12'd8), 1'b0, 5'd0, 64'd0);
    put_exp(asm_i(op_load, 5'd3, funct3_ld, 5'd1, 12'd8), 1'b1, 5'd3, val);
    put_exp(asm_r(7'd0, 5'd4, 5'd3, 5'd1), 1'b1, 5'd4, val + 64'h400);
    run_program(8'h00);
    observe(5'd3, val);
    observe(5'd4, val + 64'h400);
    close_test("load store", start);
  endtask

  task automatic test_branches();
    int start;
    start = errors;
    new_program();
    prog.push_back(asm_i(op_addi, 5'd1, 3'b000, 5'd0, 12'd5));
    prog.push_back(asm_i(op_addi, 5'd2, 3'b000, 5'd0, 12'd5));
    prog.push_back(asm_b(funct3_beq, 5'd1, 5'd2, 13'd12));
    prog.push_back(asm_i(op_addi, 5'd3, 3'b000, 5'd0, 12'd1));
    prog.push_back(asm_i(op_addi, 5'd3, 3'b000, 5'd0, 12'd2));
    prog.push_back(asm_b(funct3_bne, 5'd1, 5'd2, 13'd8));
    prog.push_back(asm_i(op_addi, 5'd4, 3'b000, 5'd0, 12'd7));
    expect_at(0, 1'b1, 5'd1, 64'd5);
    expect_at(1, 1'b1, 5'd2, 64'd5);
    expect_at(2, 1'b0, 5'd0, 64'd0); // The branch is taken and words 3 and 4 never run.
    expect_at(5, 1'b0, 5'd0, 64'd0);
    expect_at(6, 1'b1, 5'd4, 64'd7);
    run_program(8'h00);
    observe(5'd3, 64'd0);
    close_test("branches", start);
  endtask

  task automatic test_x0_write();
    int start;
    start = errors;
    new_program();
    put_exp(asm_i(op_addi, 5'd0, 3'b000, 5'd0, 12'd123), 1'b0, 5'd0, 64'd0);
    put_exp(asm_i(op_addi, 5'd1, 3'b000, 5'd0, 12'd9), 1'b1, 5'd1, 64'd9);
    put_exp(asm_r(7'd0, 5'd0, 5'd1, 5'd1), 1'b0, 5'd0, 64'd0);
    put_exp(asm_i(op_addi, 5'd2, 3'b000, 5'd0, 12'hfff), 1'b1, 5'd2, {64{1'b1}});
    run_program(8'h00);
    observe(5'd0, 64'd0);
    observe(5'd2, {64{1'b1}});
    close_test("x0 write", start);
  endtask

  task automatic test_trap();
    int start;
    start = errors;
    new_program();
    put_exp(asm_i(op_addi, 5'd10, 3'b000, 5'd0, 12'h05a), 1'b1, 5'd10, 64'h5a);
    put_exp(asm_i(op_addi, 5'd11, 3'b000, 5'd0, 12'h400), 1'b1, 5'd11, 64'h400);
    put_exp(asm_s(5'd10, 5'd11, 12'd16), 1'b0, 5'd0, 64'd0);
    put_exp(asm_i(op_load, 5'd12, funct3_ld, 5'd11, 12'd16), 1'b1, 5'd12, 64'h5a);
    put_exp(asm_b(funct3_beq, 5'd0, 5'd0, 13'd8), 1'b0, 5'd0, 64'd0);
    prog.push_back(asm_i(op_addi, 5'd10, 3'b000, 5'd0, 12'd1));
    run_program(8'h5a);
    close_test("trap", start);
  endtask

  initial begin
    reset_req  = 1'b0;
    run        = 1'b0;
    load_valid = 1'b0;
    load_addr  = '0;
    load_data  = '0;
    obs_addr   = '0;
    errors       = 0;
    tests_run    = 0;
    tests_failed = 0;
    test_alu_chain();
    test_load_store();
    test_branches();
    test_x0_write();
    test_trap();
    $display("%0d tests run, %0d failed, %0d check errors", tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

//--- build.f
rtl/rv_sim_pkg.sv
rtl/core_control_fsm.sv
rtl/commit_counter.sv
rtl/reg_file.sv
rtl/exec_unit.sv
rtl/sim_ram.sv
rtl/rv_sim_top.sv
tests/tb_clock_gen.sv
tests/rv_sim_tb.sv

//--- Bender.yml
package:
  name: rv_sim

sources:
  - rtl/rv_sim_pkg.sv
  - rtl/core_control_fsm.sv
  - rtl/commit_counter.sv
  - rtl/reg_file.sv
  - rtl/exec_unit.sv
  - rtl/sim_ram.sv
  - rtl/rv_sim_top.sv
  - target: test
    files:
      - tests/tb_clock_gen.sv
      - tests/rv_sim_tb.sv
